// ==== hdl/display_defines.svh ====
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

// visible area and full scan size in pixels and lines
`define H_ACTIVE 320
`define H_TOTAL 400
`define V_ACTIVE 240
`define V_TOTAL 262

// sync pulse windows, start inclusive and end exclusive
`define H_SYNC_START 336
`define H_SYNC_END 368
`define V_SYNC_START 244
`define V_SYNC_END 247

// tile layout, the same along both axes
// tiles start at TILE_FIRST and TILE_FIRST + TILE_PITCH
`define TILE_FIRST 20
`define TILE_PITCH 110
`define TILE_SIZE 90

// highlight box around the selected tile
// centre moves back by one tile pitch per selected row or column
`define HILITE_CENTRE 175
`define HILITE_HALF 50

`endif

// ==== hdl/displayPkg.sv ====
package displayPkg;

    // horizontal position, wide enough for the whole scan line
    typedef logic [8:0] xCoord;

    // vertical position within the visible area
    typedef logic [7:0] yCoord;

    // 4:4:4 colour, red in the top nibble
    typedef logic [11:0] rgbColour;

    // playfield palette
    localparam rgbColour colBackground = 12'h000;
    localparam rgbColour colTile = 12'h888;
    localparam rgbColour colHighlight = 12'hff0;
    localparam rgbColour colPicked = 12'hf80;

endpackage

// ==== hdl/controlPkg.sv ====
package controlPkg;

    // movement and pick commands from the button side
    typedef enum logic [2:0] {
        CMD_UP = 3'd0,
        CMD_DOWN = 3'd1,
        CMD_LEFT = 3'd2,
        CMD_RIGHT = 3'd3,
        CMD_PICK = 3'd4
    } cmdOpcode;

    // selection controller states
    typedef enum logic [1:0] {
        SEL_IDLE = 2'd0,
        SEL_WAIT_BLANK = 2'd1,
        SEL_APPLY = 2'd2
    } selState;

endpackage

// ==== hdl/vgaTiming.sv ====
`include "display_defines.svh"

module vgaTiming
    import displayPkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    output xCoord x,
    output yCoord y,
    output logic  activeArea,
    output logic  blanking,
    output logic  hsyncRaw,
    output logic  vsyncRaw,
    output logic  frameFirst
);

    // line counter needs 9 bits since V_TOTAL is past 255
    logic [8:0] hCount;
    logic [8:0] vCount;
    logic [8:0] hNext;
    logic [8:0] vNext;

    // next scan position, x wraps at H_TOTAL and y steps on each wrap
    always_comb begin
        if (hCount == 9'(`H_TOTAL - 1)) begin
            hNext = '0;
            if (vCount == 9'(`V_TOTAL - 1)) begin
                vNext = '0;
            end else begin
                vNext = vCount + 9'd1;
            end
        end else begin
            hNext = hCount + 9'd1;
            vNext = vCount;
        end
    end

    // decode flags from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (!nrst) begin
            hCount <= '0;
            vCount <= '0;
            // flags of pixel (0, 0), which is presented first out of reset
            activeArea <= 1'b1;
            blanking <= 1'b0;
            hsyncRaw <= 1'b1;
            vsyncRaw <= 1'b1;
            frameFirst <= 1'b1;
        end else begin
            hCount <= hNext;
            vCount <= vNext;
            activeArea <= (hNext < 9'(`H_ACTIVE)) && (vNext < 9'(`V_ACTIVE));
            // every line below the visible area counts as blanking
            blanking <= (vNext >= 9'(`V_ACTIVE));
            // syncs are active low
            hsyncRaw <= !((hNext >= 9'(`H_SYNC_START)) && (hNext < 9'(`H_SYNC_END)));
            vsyncRaw <= !((vNext >= 9'(`V_SYNC_START)) && (vNext < 9'(`V_SYNC_END)));
            frameFirst <= (hNext == 9'd0) && (vNext == 9'd0);
        end
    end

    assign x = hCount;
    // lines past 255 fold over here, they are all blanked anyway
    assign y = vCount[7:0];

endmodule

// ==== hdl/modSquareGenerator.sv ====
`include "display_defines.svh"

module modSquareGenerator
    import displayPkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    input  xCoord x,
    input  yCoord y,
    input  logic  modRow,
    input  logic  modCol,
    output logic  modSquaresPixel,
    output logic  modHighlightPixel
);

    logic squaresDetect;
    logic highlightDetect;
    int   centreX;
    int   centreY;

    // strictly between lo and lo + len, both edges excluded
    function automatic logic inSpan(int pos, int lo, int len);
        return (pos > lo) && (pos < lo + len);
    endfunction

    always_comb begin
        squaresDetect = 1'b0;
        // walk the 2x2 grid, first column then row
        for (int col = 0; col < 2; col++) begin
            for (int row = 0; row < 2; row++) begin
                if (inSpan(int'(x), `TILE_FIRST + col * `TILE_PITCH, `TILE_SIZE) &&
                    inSpan(int'(y), `TILE_FIRST + row * `TILE_PITCH, `TILE_SIZE)) begin
                    squaresDetect = 1'b1;
                end
            end
        end

        // selection 0 sits on the far tile, selection 1 one pitch back
        centreX = `HILITE_CENTRE - `TILE_PITCH * int'(modCol);
        centreY = `HILITE_CENTRE - `TILE_PITCH * int'(modRow);
        highlightDetect =
            inSpan(int'(x), centreX - `HILITE_HALF, 2 * `HILITE_HALF) &&
            inSpan(int'(y), centreY - `HILITE_HALF, 2 * `HILITE_HALF);
    end

    // one cycle after the coordinate
    always_ff @(posedge clk) begin
        if (!nrst) begin
            modSquaresPixel <= 1'b0;
            modHighlightPixel <= 1'b0;
        end else begin
            modSquaresPixel <= squaresDetect;
            modHighlightPixel <= highlightDetect;
        end
    end

endmodule

// ==== hdl/selectionControl.sv ====
module selectionControl
    import controlPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     blanking,
    input  logic     cmdValid,
    input  cmdOpcode cmdOp,
    output logic     cmdReady,
    output logic     modRow,
    output logic     modCol,
    output logic     picked
);

    selState state;
    selState stateNext;
    logic    transfer;

    // ready only inside vertical blanking, so the highlight never tears
    assign cmdReady = (state == SEL_WAIT_BLANK) && blanking;
    assign transfer = cmdValid && cmdReady;

    always_comb begin
        stateNext = state;
        case (state)
            SEL_IDLE: begin
                if (cmdValid) begin
                    stateNext = SEL_WAIT_BLANK;
                end
            end
            SEL_WAIT_BLANK: begin
                // command sits here under back-pressure until blanking
                if (transfer) begin
                    stateNext = SEL_APPLY;
                end
            end
            SEL_APPLY: begin
                // one quiet cycle while the sender drops its valid
                stateNext = SEL_IDLE;
            end
            default: begin
                stateNext = SEL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= SEL_IDLE;
            modRow <= 1'b0;
            modCol <= 1'b0;
            picked <= 1'b0;
        end else begin
            state <= stateNext;
            // selection changes on the clock after the transfer
            if (transfer) begin
                case (cmdOp)
                    // moves clamp at the grid edge
                    CMD_UP: begin
                        if (modRow != 1'b0) begin
                            modRow <= modRow - 1'b1;
                        end
                    end
                    CMD_DOWN: begin
                        if (modRow != 1'b1) begin
                            modRow <= modRow + 1'b1;
                        end
                    end
                    CMD_LEFT: begin
                        if (modCol != 1'b0) begin
                            modCol <= modCol - 1'b1;
                        end
                    end
                    CMD_RIGHT: begin
                        if (modCol != 1'b1) begin
                            modCol <= modCol + 1'b1;
                        end
                    end
                    CMD_PICK: begin
                        picked <= ~picked;
                    end
                    default: begin
                        // unknown opcodes are swallowed
                        picked <= picked;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/pixelMixer.sv ====
module pixelMixer
    import displayPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     activeArea,
    input  logic     hsyncRaw,
    input  logic     vsyncRaw,
    input  logic     frameFirst,
    input  logic     modSquaresPixel,
    input  logic     modHighlightPixel,
    input  logic     picked,
    output rgbColour rgb,
    output logic     hsync,
    output logic     vsync,
    output logic     frameStart
);

    // first stage, lines the timing flags up with the tile flags
    logic     activeD;
    logic     hsyncD;
    logic     vsyncD;
    logic     frameD;
    rgbColour colourNext;

    // highlight wins over tile, tile over background
    always_comb begin
        if (!activeD) begin
            colourNext = '0;
        end else if (modHighlightPixel) begin
            colourNext = picked ? colPicked : colHighlight;
        end else if (modSquaresPixel) begin
            colourNext = colTile;
        end else begin
            colourNext = colBackground;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            activeD <= 1'b0;
            hsyncD <= 1'b1;
            vsyncD <= 1'b1;
            frameD <= 1'b0;
            rgb <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            frameStart <= 1'b0;
        end else begin
            activeD <= activeArea;
            hsyncD <= hsyncRaw;
            vsyncD <= vsyncRaw;
            frameD <= frameFirst;
            // second stage, colour and syncs leave together
            rgb <= colourNext;
            hsync <= hsyncD;
            vsync <= vsyncD;
            frameStart <= frameD;
        end
    end

endmodule

// ==== hdl/puzzleDisplay.sv ====
module puzzleDisplay
    import displayPkg::*;
    import controlPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     cmdValid,
    input  cmdOpcode cmdOp,
    output logic     cmdReady,
    output rgbColour rgb,
    output logic     hsync,
    output logic     vsync,
    output logic     frameStart
);

    // scan position and timing flags
    xCoord x;
    yCoord y;
    logic  activeArea;
    logic  blanking;
    logic  hsyncRaw;
    logic  vsyncRaw;
    logic  frameFirst;

    // selection state and pixel flags
    logic modRow;
    logic modCol;
    logic picked;
    logic modSquaresPixel;
    logic modHighlightPixel;

    vgaTiming timing0 (
        .clk(clk),
        .nrst(nrst),
        .x(x),
        .y(y),
        .activeArea(activeArea),
        .blanking(blanking),
        .hsyncRaw(hsyncRaw),
        .vsyncRaw(vsyncRaw),
        .frameFirst(frameFirst)
    );

    modSquareGenerator squares0 (
        .clk(clk),
        .nrst(nrst),
        .x(x),
        .y(y),
        .modRow(modRow),
        .modCol(modCol),
        .modSquaresPixel(modSquaresPixel),
        .modHighlightPixel(modHighlightPixel)
    );

    selectionControl select0 (
        .clk(clk),
        .nrst(nrst),
        .blanking(blanking),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .cmdReady(cmdReady),
        .modRow(modRow),
        .modCol(modCol),
        .picked(picked)
    );

    // colour for pixel (x, y) leaves two clocks after timing0 shows it
    pixelMixer mixer0 (
        .clk(clk),
        .nrst(nrst),
        .activeArea(activeArea),
        .hsyncRaw(hsyncRaw),
        .vsyncRaw(vsyncRaw),
        .frameFirst(frameFirst),
        .modSquaresPixel(modSquaresPixel),
        .modHighlightPixel(modHighlightPixel),
        .picked(picked),
        .rgb(rgb),
        .hsync(hsync),
        .vsync(vsync),
        .frameStart(frameStart)
    );

endmodule

// ==== test/puzzleDisplay_chk.sv ====
`include "display_defines.svh"

module puzzleDisplay_chk
    import displayPkg::*;
    import controlPkg::*;
(
    input logic     clk,
    input logic     nrst,
    input xCoord    x,
    input logic     activeArea,
    input logic     cmdValid,
    input cmdOpcode cmdOp,
    input logic     cmdReady,
    input rgbColour rgb,
    input logic     hsync,
    input logic     vsync
);
    timeunit 1ns;
    timeprecision 100ps;

    // set once the line has shown a visible pixel so its right border stays outside blanking
    logic lineVisible;

    // cleared on the last pixel of every line
    always_ff @(posedge clk) begin
        if (!nrst) begin
            lineVisible <= 1'b0;
        end else if (x == xCoord'(`H_TOTAL - 1)) begin
            lineVisible <= 1'b0;
        end else if (activeArea) begin
            lineVisible <= 1'b1;
        end
    end

    // ready only while the scan is below the visible lines
    readyInBlank: assert property (@(posedge clk) disable iff (!nrst)
        cmdReady |-> !(activeArea || lineVisible))
        else $error("cmdReady high outside vertical blanking");

    // sender keeps the opcode steady under back-pressure
    opStable: assert property (@(posedge clk) disable iff (!nrst)
        (cmdValid && !cmdReady) |=> $stable(cmdOp))
        else $error("cmdOp changed while waiting for cmdReady");

    // idle video outputs right after a reset cycle
    resetIdle: assert property (@(posedge clk) !nrst |=> (hsync && vsync && rgb == '0))
        else $error("video outputs not idle after reset");

endmodule

bind puzzleDisplay puzzleDisplay_chk chk0 (
    .clk(clk),
    .nrst(nrst),
    .x(x),
    .activeArea(activeArea),
    .cmdValid(cmdValid),
    .cmdOp(cmdOp),
    .cmdReady(cmdReady),
    .rgb(rgb),
    .hsync(hsync),
    .vsync(vsync)
);

// ==== test/puzzleDisplay_tb.sv ====
`include "display_defines.svh"

module puzzleDisplay_tb
    import displayPkg::*;
    import controlPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // colour leaves two clocks after the scan position
    localparam int LATENCY = 2;
    // rgb index when the first blanking line reaches the selection logic
    localparam int ACCEPT_POS = `V_ACTIVE * `H_TOTAL - LATENCY;
    localparam int WAIT_LIMIT = `H_TOTAL * `V_TOTAL + 1000;

    logic     clk;
    logic     nrst;
    logic     cmdValid;
    cmdOpcode cmdOp;
    logic     cmdReady;
    rgbColour rgb;
    logic     hsync;
    logic     vsync;
    logic     frameStart;

    // kind in [35:32], x in [31:20], y in [19:12], colour or opcode in [11:0]
    logic [35:0] vectors [0:63];

    // scan index of the pixel now on rgb, counted from the last frameStart
    int pos;
    int frames;
    int errors;
    int checks;
    int testErrors;
    int testChecks;
    int testNo;
    bit aborted;
    bit pending;
    bit needFrame;

    puzzleDisplay dut0 (
        .clk(clk),
        .nrst(nrst),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .cmdReady(cmdReady),
        .rgb(rgb),
        .hsync(hsync),
        .vsync(vsync),
        .frameStart(frameStart)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // one cycle, sampled on the falling edge where outputs are settled
    task automatic tick();
        @(negedge clk);
        if (frameStart) begin
            pos = 0;
            frames++;
        end else begin
            pos++;
        end
    endtask

    task automatic abortRun(string why);
        $display("Error at %0t: %s", $time, why);
        errors++;
        testErrors++;
        aborted = 1'b1;
    endtask

    task automatic checkColour(rgbColour got, rgbColour exp, string name);
        checks++;
        testChecks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkSel(bit got, bit exp, string name);
        checks++;
        testChecks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0b expected %0b", $time, name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic waitFrame();
        int seen;
        int t;
        seen = frames;
        t = 0;
        while (frames == seen && t < WAIT_LIMIT && !aborted) begin
            tick();
            t++;
        end
        if (frames == seen && !aborted) begin
            abortRun("no frameStart seen within one frame time");
        end
    endtask

    // hold until the transfer, then drop valid just after that edge
    task automatic finishCommand();
        int t;
        tick();
        t = 1;
        while (!(cmdValid && cmdReady) && t < WAIT_LIMIT && !aborted) begin
            tick();
            t++;
        end
        if (!aborted && !(cmdValid && cmdReady)) begin
            abortRun("command was never accepted by the DUT");
        end else if (!aborted) begin
            checkSel(pos == ACCEPT_POS, 1'b1, "cmdReady at first blanking cycle");
        end
        @(posedge clk);
        #2;
        cmdValid = 1'b0;
        pending = 1'b0;
    endtask

    // issue a command early in a frame after a random idle gap
    task automatic sendCommand(cmdOpcode op, bit hold);
        int gap;
        waitFrame();
        if (!aborted) begin
            gap = int'($urandom_range(200, 1));
            repeat (gap) tick();
            @(posedge clk);
            #2;
            cmdValid = 1'b1;
            cmdOp = op;
            if (!hold) begin
                finishCommand();
            end
        end
    endtask

    task automatic checkProbe(logic [35:0] vec);
        xCoord px;
        yCoord py;
        int    target;
        int    t;
        px = vec[28:20];
        py = vec[19:12];
        target = int'(py) * `H_TOTAL + int'(px);
        if (needFrame) begin
            waitFrame();
            needFrame = 1'b0;
        end
        t = 0;
        while (pos != target && t < WAIT_LIMIT && !aborted) begin
            tick();
            t++;
        end
        if (pos != target && !aborted) begin
            abortRun($sformatf("probe pixel (%0d,%0d) never reached", px, py));
        end else if (!aborted) begin
            checkColour(rgb, rgbColour'(vec[11:0]), $sformatf("rgb at (%0d,%0d)", px, py));
        end
    endtask

    task automatic endTest();
        if (pending) begin
            finishCommand();
        end
        $display("test %0d done: %0d checks, %0d errors", testNo, testChecks, testErrors);
        testNo++;
        testChecks = 0;
        testErrors = 0;
        needFrame = 1'b1;
    endtask

    initial begin
        int idx;
        void'($urandom(32'hd6e7));
        nrst = 1'b0;
        cmdValid = 1'b0;
        cmdOp = CMD_UP;
        pos = 0;
        frames = 0;
        errors = 0;
        checks = 0;
        testErrors = 0;
        testChecks = 0;
        testNo = 0;
        aborted = 1'b0;
        pending = 1'b0;
        needFrame = 1'b1;
        $readmemh("test/puzzle_vectors.txt", vectors);

        // outputs sit at their idle values while reset is held
        repeat (15) tick();
        checkSel(hsync, 1'b1, "hsync");
        checkSel(vsync, 1'b1, "vsync");
        checkSel(cmdReady, 1'b0, "cmdReady");
        checkSel(frameStart, 1'b0, "frameStart");
        checkColour(rgb, colBackground, "rgb");
        @(posedge clk);
        #2;
        nrst = 1'b1;
        endTest();

        if ($isunknown(vectors[0])) begin
            abortRun("vector file is missing or empty");
        end
        idx = 0;
        while (!aborted && idx < 64 && vectors[idx][35:32] != 4'hf) begin
            case (vectors[idx][35:32])
                4'h0: begin
                    sendCommand(cmdOpcode'(vectors[idx][2:0]), 1'b0);
                    needFrame = 1'b1;
                end
                4'h1: begin
                    // left pending while the current frame is probed
                    sendCommand(cmdOpcode'(vectors[idx][2:0]), 1'b1);
                    pending = 1'b1;
                    needFrame = 1'b0;
                end
                4'h2: checkProbe(vectors[idx]);
                4'h3: endTest();
                default: abortRun("unknown line kind in the vector file");
            endcase
            idx++;
        end

        $display("tests %0d, checks %0d, errors %0d", testNo, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/puzzle_vectors.txt ====
// columns kind_x_y_data in hex: kind 0 command, 1 command held over the probed frame,
// 2 probe with expected rgb in data, 3 end of test, f end of list; opcode sits in data
2_041_41_888 // (65,65) tile, selection row 0 col 0
2_07e_af_ff0 // (126,175) highlight beside the tile
2_0af_af_ff0 // (175,175) highlight over tile
3_000_00_000
2_032_14_000 // (50,20) top edge excluded
2_032_15_888 // (50,21)
2_014_32_000 // (20,50) left edge excluded
2_015_32_888 // (21,50)
2_06e_32_000 // (110,50) right edge excluded
2_14a_32_000 // (330,50) outside the active area
3_000_00_000
0_000_00_003 // right, now row 0 col 1
2_010_af_ff0 // (16,175)
2_041_af_ff0 // (65,175) highlight wins over tile
2_073_af_000 // (115,175)
2_0af_af_888 // (175,175)
3_000_00_000
0_000_00_001 // down, now row 1 col 1
2_041_41_ff0 // (65,65)
2_041_af_888 // (65,175)
3_000_00_000
0_000_00_001 // down, clamps
0_000_00_003 // right, clamps
0_000_00_002 // left
0_000_00_002 // left, clamps at row 1 col 0
2_041_41_888 // (65,65)
2_0af_41_ff0 // (175,65)
3_000_00_000
0_000_00_004 // pick
2_041_41_888 // (65,65)
2_0af_41_f80 // (175,65) picked
3_000_00_000
1_000_00_004 // pick issued mid-frame, current frame unchanged
2_0af_41_f80 // (175,65)
3_000_00_000
2_0af_41_ff0 // (175,65) pick cleared in the next frame
3_000_00_000
f_000_00_000

// ==== build.f ====
+incdir+hdl
hdl/displayPkg.sv
hdl/controlPkg.sv
hdl/vgaTiming.sv
hdl/modSquareGenerator.sv
hdl/selectionControl.sv
hdl/pixelMixer.sv
hdl/puzzleDisplay.sv
test/puzzleDisplay_chk.sv
test/puzzleDisplay_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module puzzleDisplay_tb \
    -Mdir obj_dir -o puzzleDisplay_sim

./obj_dir/puzzleDisplay_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
